// File: colmix_params.svh
/*
 * Colour mixer widths and counts: palette address, layers,
 * layer priority field and brightness level
 */
`ifndef COLMIX_PARAMS_SVH
`define COLMIX_PARAMS_SVH

// 2048 palette words
`define COLMIX_PAL_AW 11

// fix, scroll A, scroll B, objects
`define COLMIX_NUM_LAYERS 4

// per-layer priority, lower value is in front
`define COLMIX_PRI_W 6

// 16 brightness levels
`define COLMIX_LVL_W 4

`endif

// File: flist.f
+incdir+.
logic/colmix_pkg.sv
logic/colmix_ctrl.sv
logic/prio_mixer.sv
logic/palette_ram.sv
logic/bright_lut.sv
logic/colmix_top.sv
sim/colmix_tb.sv

// File: logic/bright_lut.sv
/*
 * Brightness stage: 5 to 8 bit expansion, level scaling on two
 * time-shared ports, RGB output register and blanking
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module bright_lut (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::phase_t        phase,
    input  logic [`COLMIX_LVL_W-1:0]  level,
    input  logic [15:0]               pal_data,
    input  logic                      lhbl,
    input  logic                      lvbl,
    output colmix_pkg::rgb_t          rgb
);

    logic [4:0]               pal_dmux;
    logic [`COLMIX_LVL_W-1:0] lvl_q;
    logic [7:0]               port1;
    logic [7:0]               port2;
    logic [7:0]               red8;
    logic [7:0]               grn8;
    colmix_pkg::rgb_t         rgb_q;

    // widen, then scale by (level+1)/16
    function automatic logic [7:0] scale(
        input logic [4:0]               c,
        input logic [`COLMIX_LVL_W-1:0] lvl
    );
        logic [7:0]  c8;
        logic [11:0] prod;
        c8   = {c, c[4:2]};
        prod = c8 * ({1'b0, lvl} + 5'd1);
        return prod[11:4];
    endfunction

    // port one is red only, port two takes the mux register
    assign port1 = scale(pal_data[4:0], lvl_q);
    assign port2 = scale(pal_dmux, lvl_q);

    always_ff @(posedge clk) begin
        // level of the pixel whose colour is now in the RAM output
        if (pxl_cen) begin
            lvl_q <= level;
        end
        // green loaded in PH_RED_GREEN, blue in PH_BLUE
        if (phase == colmix_pkg::PH_RED_GREEN) begin
            pal_dmux <= pal_data[9:5];
        end else begin
            pal_dmux <= pal_data[14:10];
        end
        if (phase == colmix_pkg::PH_BLUE) begin
            red8 <= port1;
            grn8 <= port2;
        end
    end

    // blue is still on port two at the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_q <= '0;
        end else if (pxl_cen) begin
            rgb_q.red   <= red8;
            rgb_q.green <= grn8;
            rgb_q.blue  <= port2;
        end
    end

    assign rgb = (lhbl && lvbl) ? rgb_q : '0;

endmodule

// File: logic/colmix_ctrl.sv
/*
 * CPU decode for palette and mixer registers, layer priorities,
 * brightness registers, pixel phase and level select
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module colmix_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::cpu_bus_t      cpu,
    input  logic                      shadow,
    output colmix_pkg::pri_set_t      pri,
    output logic [1:0]                pal_we,
    output colmix_pkg::phase_t        phase,
    output logic [`COLMIX_LVL_W-1:0]  level
);

    logic                     mix_we;
    colmix_pkg::mix_reg_t     reg_sel;
    logic [`COLMIX_LVL_W-1:0] bright_lvl;
    logic [`COLMIX_LVL_W-1:0] shadow_lvl;

    // byte lanes follow the active-low data strobes
    assign pal_we  = {2{cpu.pal_cs & cpu.we}} & ~cpu.dsn;

    // mixer registers sit on the low byte only
    assign mix_we  = cpu.mix_cs & cpu.we & ~cpu.dsn[0];
    assign reg_sel = colmix_pkg::mix_reg_t'(cpu.addr[2:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // all ones puts every layer at the back
            pri        <= '1;
            bright_lvl <= `COLMIX_LVL_W'(15);
            shadow_lvl <= `COLMIX_LVL_W'(7);
        end else if (mix_we) begin
            case (reg_sel)
                colmix_pkg::REG_PRI_FIX: pri.fix  <= cpu.dout[`COLMIX_PRI_W-1:0];
                colmix_pkg::REG_PRI_A:   pri.lyra <= cpu.dout[`COLMIX_PRI_W-1:0];
                colmix_pkg::REG_PRI_B:   pri.lyrb <= cpu.dout[`COLMIX_PRI_W-1:0];
                colmix_pkg::REG_PRI_OBJ: pri.obj  <= cpu.dout[`COLMIX_PRI_W-1:0];
                colmix_pkg::REG_BRIGHT:  bright_lvl <= cpu.dout[`COLMIX_LVL_W-1:0];
                colmix_pkg::REG_SHADOW:  shadow_lvl <= cpu.dout[`COLMIX_LVL_W-1:0];
                default: ;
            endcase
        end
    end

    // two clocks per pixel, realigned on every strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= colmix_pkg::PH_RED_GREEN;
        end else if (pxl_cen) begin
            phase <= colmix_pkg::PH_BLUE;
        end else if (phase == colmix_pkg::PH_BLUE) begin
            phase <= colmix_pkg::PH_RED_GREEN;
        end else begin
            phase <= colmix_pkg::PH_BLUE;
        end
    end

    // shadowed objects darken to the shadow level
    assign level = shadow ? shadow_lvl : bright_lvl;

endmodule

// File: logic/colmix_pkg.sv
/*
 * Colour mixer types: layer pixels, CPU strobes, output colour,
 * pixel phase, mixer register select and the priority set
 */
`include "colmix_params.svh"

package colmix_pkg;

    // one pixel from every layer, fix in the top bits
    typedef struct packed {
        logic [7:0]  fix;
        logic [11:0] lyra;
        logic [11:0] lyrb;
        logic [11:0] obj;
        logic        obj_shd;
    } layer_pxl_t;

    // single-cycle CPU strobes, dsn is active low
    typedef struct packed {
        logic        pal_cs;
        logic        mix_cs;
        logic        we;
        logic [1:0]  dsn;
        logic [11:0] addr;
        logic [15:0] dout;
    } cpu_bus_t;

    // same order as the 5:5:5 palette word, blue on top
    typedef struct packed {
        logic [7:0] blue;
        logic [7:0] green;
        logic [7:0] red;
    } rgb_t;

    // the pixel strobe always falls in PH_RED_GREEN
    typedef enum logic {
        PH_RED_GREEN = 1'b0,
        PH_BLUE      = 1'b1
    } phase_t;

    // mixer register map, addresses 6 and 7 unused
    typedef enum logic [2:0] {
        REG_PRI_FIX = 3'd0,
        REG_PRI_A   = 3'd1,
        REG_PRI_B   = 3'd2,
        REG_PRI_OBJ = 3'd3,
        REG_BRIGHT  = 3'd4,
        REG_SHADOW  = 3'd5
    } mix_reg_t;

    typedef struct packed {
        logic [`COLMIX_PRI_W-1:0] fix;
        logic [`COLMIX_PRI_W-1:0] lyra;
        logic [`COLMIX_PRI_W-1:0] lyrb;
        logic [`COLMIX_PRI_W-1:0] obj;
    } pri_set_t;

endpackage

// File: logic/colmix_top.sv
/*
 * Colour mixer top: control, priority mixer,
 * palette RAM and brightness stage
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module colmix_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  colmix_pkg::layer_pxl_t pxl,
    input  colmix_pkg::cpu_bus_t   cpu,
    output logic [15:0]            cpu_din,
    output colmix_pkg::rgb_t       rgb
);

    colmix_pkg::pri_set_t      pri;
    colmix_pkg::phase_t        phase;
    logic [1:0]                pal_we;
    logic [`COLMIX_LVL_W-1:0]  level;
    logic [`COLMIX_PAL_AW-1:0] pal_addr;
    logic                      shadow;
    logic [15:0]               pal_data;

    colmix_ctrl u_ctrl (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .cpu      ( cpu      ),
        .shadow   ( shadow   ),
        .pri      ( pri      ),
        .pal_we   ( pal_we   ),
        .phase    ( phase    ),
        .level    ( level    )
    );

    prio_mixer u_mixer (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pxl      ( pxl      ),
        .pri      ( pri      ),
        .pal_addr ( pal_addr ),
        .shadow   ( shadow   )
    );

    // CPU word address, top bit unused
    palette_ram u_pal (
        .clk      ( clk                            ),
        .cpu_addr ( cpu.addr[`COLMIX_PAL_AW-1:0]   ),
        .cpu_data ( cpu.dout                       ),
        .pal_we   ( pal_we                         ),
        .pal_addr ( pal_addr                       ),
        .cpu_din  ( cpu_din                        ),
        .pal_data ( pal_data                       )
    );

    bright_lut u_bright (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .phase    ( phase    ),
        .level    ( level    ),
        .pal_data ( pal_data ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .rgb      ( rgb      )
    );

endmodule

// File: logic/palette_ram.sv
/*
 * Palette memory, 2048 x 16, byte-writable CPU port
 * and read-only pixel port
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module palette_ram (
    input  logic                      clk,
    input  logic [`COLMIX_PAL_AW-1:0] cpu_addr,
    input  logic [15:0]               cpu_data,
    input  logic [1:0]                pal_we,
    input  logic [`COLMIX_PAL_AW-1:0] pal_addr,
    output logic [15:0]               cpu_din,
    output logic [15:0]               pal_data
);

    localparam int DEPTH = 2 ** `COLMIX_PAL_AW;

    logic [15:0] mem [DEPTH];

    // CPU side, one enable per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (pal_we[b]) begin
                mem[cpu_addr][b*8 +: 8] <= cpu_data[b*8 +: 8];
            end
        end
        // old word comes back during a write
        cpu_din <= mem[cpu_addr];
    end

    // video side reads every clock
    always_ff @(posedge clk) begin
        pal_data <= mem[pal_addr];
    end

endmodule

// File: logic/prio_mixer.sv
/*
 * Layer priority mixer: transparency test, front layer search,
 * palette address and object shadow flag
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module prio_mixer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  colmix_pkg::layer_pxl_t    pxl,
    input  colmix_pkg::pri_set_t      pri,
    output logic [`COLMIX_PAL_AW-1:0] pal_addr,
    output logic                      shadow
);

    localparam int IW = $clog2(`COLMIX_NUM_LAYERS);
    localparam int CW = `COLMIX_PAL_AW - IW;
    localparam logic [IW-1:0] OBJ_IDX = IW'(`COLMIX_NUM_LAYERS - 1);

    logic [CW-1:0]              col  [`COLMIX_NUM_LAYERS];
    logic [`COLMIX_PRI_W-1:0]   prio [`COLMIX_NUM_LAYERS];
    logic                       win_found;
    logic [IW-1:0]              win_idx;
    logic [`COLMIX_PRI_W-1:0]   win_pri;

    // layer index order is fix, A, B, obj
    always_comb begin
        col[0]  = CW'(pxl.fix);
        col[1]  = pxl.lyra[CW-1:0];
        col[2]  = pxl.lyrb[CW-1:0];
        col[3]  = pxl.obj[CW-1:0];
        prio[0] = pri.fix;
        prio[1] = pri.lyra;
        prio[2] = pri.lyrb;
        prio[3] = pri.obj;
    end

    // strict compare keeps ties on the lower index
    always_comb begin
        win_found = 1'b0;
        win_idx   = '0;
        win_pri   = '1;
        for (int i = 0; i < `COLMIX_NUM_LAYERS; i++) begin
            // pen 0 of each palette is see-through
            if (|col[i][3:0] && (!win_found || prio[i] < win_pri)) begin
                win_found = 1'b1;
                win_idx   = IW'(i);
                win_pri   = prio[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= '0;
            shadow   <= 1'b0;
        end else if (pxl_cen) begin
            // nothing opaque falls back to entry 0
            pal_addr <= win_found ? {win_idx, col[win_idx]} : '0;
            shadow   <= win_found && win_idx == OBJ_IDX && pxl.obj_shd;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the colour mixer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module colmix_tb -o colmix_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/colmix_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: sim/colmix_tb.sv
/*
 * Colour mixer testbench: clock, reset, LFSR stimulus, palette and
 * mixer models, directed tests, timeout and verdict
 */
`timescale 1ns/10ps
`include "colmix_params.svh"

module colmix_tb;

    localparam int RESET_CYCLES = 8;
    localparam int PAL_WORDS    = 64;
    localparam int TIE_PIXELS   = 16;
    localparam int PRIO_PIXELS  = 80;
    localparam int BRIGHT_STEPS = 16;
    localparam int SHADOW_CASES = 4;
    localparam int BLANK_STEPS  = 4;
    localparam int REG_WRITES   = 80;
    // one palette write plus up to eight clocks for four strobes
    localparam int PIXEL_CYCLES = 12;
    localparam int TEST_CYCLES  = RESET_CYCLES + PAL_WORDS * 8 + REG_WRITES + BLANK_STEPS
        + (TIE_PIXELS + PRIO_PIXELS + BRIGHT_STEPS + SHADOW_CASES + 3) * PIXEL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic                   lhbl;
    logic                   lvbl;
    colmix_pkg::layer_pxl_t pxl;
    colmix_pkg::cpu_bus_t   cpu;
    logic [15:0]            cpu_din;
    colmix_pkg::rgb_t       rgb;

    logic [15:0] pal_model [2 ** `COLMIX_PAL_AW];
    logic [5:0]  pri_model [4];
    logic [3:0]  bright_model;
    logic [3:0]  shadow_model;
    logic [23:0] last_colour;
    logic [31:0] lfsr = 32'ha177_927e;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    colmix_top dut_i (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .pxl     ( pxl     ),
        .cpu     ( cpu     ),
        .cpu_din ( cpu_din ),
        .rgb     ( rgb     )
    );

    always #10 clk = ~clk;

    // one pixel every second clock
    always @(negedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // galois LFSR on x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        out;
        v = '0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            v = {v[30:0], out};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic wait_strobes(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (pxl_cen) begin
                seen++;
            end
        end
        @(negedge clk);
    endtask

    // 5 bit component widened then scaled by (level+1)/16
    function automatic logic [7:0] scale_component(input logic [4:0] c, input logic [3:0] lvl);
        logic [31:0] wide;
        logic [31:0] scaled;
        wide   = {24'd0, c, c[4:2]};
        scaled = wide * ({28'd0, lvl} + 32'd1);
        return scaled[11:4];
    endfunction

    function automatic logic [23:0] model_colour(input logic [15:0] word, input logic [3:0] lvl);
        return {scale_component(word[14:10], lvl), scale_component(word[9:5], lvl),
                scale_component(word[4:0], lvl)};
    endfunction

    // front opaque layer with ties kept by the lower index
    task automatic find_winner(input colmix_pkg::layer_pxl_t p, output logic [10:0] addr,
                               output logic obj_front);
        logic [8:0] col [4];
        logic       found;
        logic [1:0] best;
        col[0] = {1'b0, p.fix};
        col[1] = p.lyra[8:0];
        col[2] = p.lyrb[8:0];
        col[3] = p.obj[8:0];
        found  = 1'b0;
        best   = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (col[i][3:0] != 4'd0 && (!found || pri_model[i] < pri_model[best])) begin
                found = 1'b1;
                best  = 2'(i);
            end
        end
        addr      = found ? {best, col[best]} : 11'd0;
        obj_front = found && best == 2'd3;
    endtask

    function automatic colmix_pkg::layer_pxl_t random_pixel();
        colmix_pkg::layer_pxl_t p;
        p.fix     = 8'(rand_bits(8));
        p.lyra    = 12'(rand_bits(12));
        p.lyrb    = 12'(rand_bits(12));
        p.obj     = 12'(rand_bits(12));
        p.obj_shd = 1'(rand_bits(1));
        // roughly a quarter of the layers see-through
        if (rand_bits(2) == 32'd0) p.fix[3:0] = 4'd0;
        if (rand_bits(2) == 32'd0) p.lyra[3:0] = 4'd0;
        if (rand_bits(2) == 32'd0) p.lyrb[3:0] = 4'd0;
        if (rand_bits(2) == 32'd0) p.obj[3:0] = 4'd0;
        return p;
    endfunction

    task automatic write_palette(input logic [10:0] addr, input logic [15:0] data,
                                 input logic [1:0] dsn);
        cpu.pal_cs = 1'b1;
        cpu.we     = 1'b1;
        cpu.dsn    = dsn;
        cpu.addr   = {1'b0, addr};
        cpu.dout   = data;
        if (!dsn[0]) pal_model[addr][7:0] = data[7:0];
        if (!dsn[1]) pal_model[addr][15:8] = data[15:8];
        @(negedge clk);
        cpu.pal_cs = 1'b0;
        cpu.we     = 1'b0;
        cpu.dsn    = 2'b11;
    endtask

    task automatic read_palette_back(input logic [10:0] addr);
        cpu.addr = {1'b0, addr};
        @(negedge clk);
        check_value("cpu_din", {16'd0, cpu_din}, {16'd0, pal_model[addr]});
    endtask

    task automatic write_mixer_reg(input logic [2:0] sel, input logic [5:0] data);
        cpu.mix_cs = 1'b1;
        cpu.we     = 1'b1;
        cpu.dsn    = 2'b10;
        cpu.addr   = {9'd0, sel};
        cpu.dout   = {10'd0, data};
        case (sel)
            colmix_pkg::REG_PRI_FIX: pri_model[0] = data;
            colmix_pkg::REG_PRI_A:   pri_model[1] = data;
            colmix_pkg::REG_PRI_B:   pri_model[2] = data;
            colmix_pkg::REG_PRI_OBJ: pri_model[3] = data;
            colmix_pkg::REG_BRIGHT:  bright_model = data[3:0];
            colmix_pkg::REG_SHADOW:  shadow_model = data[3:0];
            default: ;
        endcase
        @(negedge clk);
        cpu.mix_cs = 1'b0;
        cpu.we     = 1'b0;
        cpu.dsn    = 2'b11;
    endtask

    // fresh colour at the winner entry then hold the pixel past the pipeline
    task automatic show_pixel(input colmix_pkg::layer_pxl_t p);
        logic [10:0] addr;
        logic        obj_front;
        logic [3:0]  lvl;
        find_winner(p, addr, obj_front);
        pxl = p;
        write_palette(addr, 16'(rand_bits(16)), 2'b00);
        wait_strobes(4);
        lvl = (obj_front && p.obj_shd) ? shadow_model : bright_model;
        last_colour = model_colour(pal_model[addr], lvl);
        check_value("rgb", {8'd0, rgb}, {8'd0, last_colour});
    endtask

    task automatic reset_state();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("rgb", {8'd0, rgb}, 32'd0);
        rst = 1'b0;
    endtask

    task automatic palette_access();
        logic [10:0] addr;
        for (int w = 0; w < PAL_WORDS; w++) begin
            addr = 11'(rand_bits(11));
            write_palette(addr, 16'(rand_bits(16)), 2'b00);
            read_palette_back(addr);
            for (int d = 1; d < 4; d++) begin
                write_palette(addr, 16'(rand_bits(16)), 2'(d));
                read_palette_back(addr);
            end
        end
    endtask

    task automatic tie_break();
        logic [5:0] same;
        // reset priorities are already all equal
        for (int i = 0; i < TIE_PIXELS / 2; i++) begin
            show_pixel(random_pixel());
        end
        same = 6'(rand_bits(6));
        for (int r = 0; r < 4; r++) begin
            write_mixer_reg(3'(r), same);
        end
        for (int i = 0; i < TIE_PIXELS / 2; i++) begin
            show_pixel(random_pixel());
        end
    endtask

    task automatic priority_order();
        colmix_pkg::layer_pxl_t p;
        for (int i = 0; i < PRIO_PIXELS; i++) begin
            if (i % 8 == 0) begin
                for (int r = 0; r < 4; r++) begin
                    write_mixer_reg(3'(r), 6'(rand_bits(6)));
                end
            end
            show_pixel(random_pixel());
        end
        // unused register address leaves everything alone
        write_mixer_reg(3'd6, 6'(rand_bits(6)));
        p = random_pixel();
        show_pixel(p);
        // backdrop
        p.fix[3:0]  = 4'd0;
        p.lyra[3:0] = 4'd0;
        p.lyrb[3:0] = 4'd0;
        p.obj[3:0]  = 4'd0;
        show_pixel(p);
    endtask

    task automatic brightness_levels();
        colmix_pkg::layer_pxl_t p;
        for (int l = 0; l < BRIGHT_STEPS; l++) begin
            write_mixer_reg(colmix_pkg::REG_BRIGHT, 6'(l));
            p = random_pixel();
            p.obj_shd = 1'b0;
            show_pixel(p);
        end
    endtask

    task automatic shadow_select();
        colmix_pkg::layer_pxl_t p;
        write_mixer_reg(colmix_pkg::REG_PRI_FIX, 6'd20);
        write_mixer_reg(colmix_pkg::REG_PRI_A, 6'd30);
        write_mixer_reg(colmix_pkg::REG_PRI_B, 6'd40);
        write_mixer_reg(colmix_pkg::REG_PRI_OBJ, 6'd5);
        write_mixer_reg(colmix_pkg::REG_BRIGHT, 6'd13);
        write_mixer_reg(colmix_pkg::REG_SHADOW, 6'd4);
        p = random_pixel();
        p.fix[0]  = 1'b1;
        p.obj[0]  = 1'b1;
        p.obj_shd = 1'b1;
        show_pixel(p);
        // fix now in front of the object
        write_mixer_reg(colmix_pkg::REG_PRI_FIX, 6'd2);
        show_pixel(p);
        write_mixer_reg(colmix_pkg::REG_PRI_FIX, 6'd20);
        p.obj_shd = 1'b0;
        show_pixel(p);
        write_mixer_reg(colmix_pkg::REG_SHADOW, 6'd0);
        p.obj_shd = 1'b1;
        show_pixel(p);
    endtask

    task automatic blanking();
        show_pixel(random_pixel());
        lhbl = 1'b0;
        @(negedge clk);
        check_value("rgb", {8'd0, rgb}, 32'd0);
        lhbl = 1'b1;
        lvbl = 1'b0;
        @(negedge clk);
        check_value("rgb", {8'd0, rgb}, 32'd0);
        lhbl = 1'b0;
        @(negedge clk);
        check_value("rgb", {8'd0, rgb}, 32'd0);
        lhbl = 1'b1;
        lvbl = 1'b1;
        @(negedge clk);
        check_value("rgb", {8'd0, rgb}, {8'd0, last_colour});
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pxl_cen    = 1'b0;
        lhbl       = 1'b1;
        lvbl       = 1'b1;
        pxl        = '0;
        cpu        = '0;
        cpu.dsn    = 2'b11;
        for (int i = 0; i < 4; i++) begin
            pri_model[i] = 6'h3f;
        end
        bright_model = 4'd15;
        shadow_model = 4'd7;
        last_colour  = '0;

        reset_state();
        palette_access();
        tie_break();
        priority_order();
        brightness_levels();
        shadow_select();
        blanking();

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
